// File: fsync_pkg.sv
package fsync_pkg;

  localparam int unsigned AGGR_W  = 4;  // aggregate mask, one bit per tree level.
  localparam int unsigned LEVEL_W = 2;  // encoded level index into aggr.
  localparam int unsigned ID_W    = 3;  // barrier id, also the register file index.
  localparam int unsigned SRC_W   = 4;  // source/destination tag of a request.
  localparam int unsigned SD_W    = 2;  // sub-tree mask added on each forward.

  // both children of this node took part in the barrier.
  localparam logic [SD_W-1:0] SD_BOTH = 2'b11;

  // request arriving on an RX port.
  typedef struct packed {
    logic              root;  // node is the root for this barrier.
    logic [AGGR_W-1:0] aggr;  // remaining levels to aggregate.
    logic [ID_W-1:0]   id;    // barrier id.
    logic [SRC_W-1:0]  src;   // requester tag.
  } sync_req_t;

  // wake-up or error response back towards the requester.
  typedef struct packed {
    logic             wake;   // release the waiting requester.
    logic             error;  // barrier failed.
    logic [SRC_W-1:0] dst;    // requester to be released.
  } sync_rsp_t;

  // request sent one level up the tree.
  typedef struct packed {
    logic [AGGR_W-1:0]     aggr;  // aggr shifted by one level.
    logic [ID_W-1:0]       id;    // unchanged barrier id.
    logic [SRC_W+SD_W-1:0] src;   // own src extended by the sub-tree mask.
  } fwd_req_t;

endpackage

// File: fsync_ctrl_pkg.sv
package fsync_ctrl_pkg;

  // per-port controller FSM.
  typedef enum logic [1:0] {
    IDLE,   // ready for a new request.
    CHECK,  // waiting for register file access.
    PUSH    // writing the outcome into a FIFO.
  } ctrl_state_e;

  // outcome of a register file lookup.
  typedef enum logic [1:0] {
    STORED,   // first arrival, entry now pending.
    PAIRED,   // second arrival completed the barrier.
    MISMATCH  // level or port conflict with the pending arrival.
  } rf_result_e;

  // lookup issued by a controller.
  typedef struct packed {
    logic [fsync_pkg::LEVEL_W-1:0] level;  // tree level of the request.
    logic [fsync_pkg::ID_W-1:0]    id;     // entry index.
    logic [fsync_pkg::SRC_W-1:0]   src;    // tag stored on first arrival.
    logic                          port;   // issuing RX port.
  } rf_access_t;

  // answer from the register file.
  typedef struct packed {
    rf_result_e                  result;  // lookup outcome.
    logic [fsync_pkg::SRC_W-1:0] src;     // src of the pending arrival.
  } rf_reply_t;

endpackage

// File: fsync_fifo.sv
`timescale 1ns/10ps

module fsync_fifo #(
  parameter int unsigned FIFO_DEPTH = 2,
  parameter type         element_t  = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  element_t element_i,
  input  logic     pop_i,
  output element_t element_o,
  output logic     empty_o,
  output logic     full_o,
  output logic     underflow_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  element_t   mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_en;
  logic             pop_en;

  assign empty_o     = (count_q == '0);
  assign full_o      = (count_q == CNT_W'(FIFO_DEPTH));
  assign push_en     = push_i & ~full_o;   // overflow push is dropped.
  assign pop_en      = pop_i & ~empty_o;
  assign underflow_o = pop_i & empty_o;    // one pulse per bad pop.
  assign element_o   = mem_q[rd_ptr_q];    // head valid while not empty.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push_en) - CNT_W'(pop_en);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= element_i;
    end
  end

endmodule

// File: fsync_rf_arbiter.sv
`timescale 1ns/10ps

module fsync_rf_arbiter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [1:0]                 req_i,
  input  fsync_ctrl_pkg::rf_access_t access_i [2],
  output logic [1:0]                 gnt_o,
  output fsync_ctrl_pkg::rf_access_t access_o,
  output logic                       valid_o
);

  logic prio_q;  // port that wins a tie.
  logic winner;  // index of the granted port.

  always_comb begin
    if (req_i == 2'b11) begin
      winner = prio_q;  // contention resolved by the pointer.
    end else begin
      winner = req_i[1];  // single requester wins.
    end
  end

  assign valid_o  = |req_i;
  assign gnt_o    = valid_o ? (2'b01 << winner) : 2'b00;
  assign access_o = access_i[winner];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= 1'b0;
    end else if (valid_o) begin
      prio_q <= ~winner;  // the other port goes first next time.
    end
  end

endmodule

// File: fsync_local_rf.sv
`timescale 1ns/10ps

module fsync_local_rf (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       valid_i,
  input  fsync_ctrl_pkg::rf_access_t access_i,
  output fsync_ctrl_pkg::rf_reply_t  reply_o
);

  localparam int unsigned N_ENTRIES = 2 ** fsync_pkg::ID_W;  // one entry per barrier id.

  // first arrival as recorded in an entry.
  typedef struct packed {
    logic [fsync_pkg::LEVEL_W-1:0] level;
    logic [fsync_pkg::SRC_W-1:0]   src;
    logic                          port;
  } rf_entry_t;

  logic [N_ENTRIES-1:0]       pending_q;  // entry holds a first arrival.
  rf_entry_t                  entry_q [N_ENTRIES];
  rf_entry_t                  entry;      // entry selected by id.
  logic                       pending;
  fsync_ctrl_pkg::rf_result_e result;

  assign entry   = entry_q[access_i.id];
  assign pending = pending_q[access_i.id];

  always_comb begin
    if (!pending) begin
      result = fsync_ctrl_pkg::STORED;  // nobody waiting yet.
    end else if (entry.level == access_i.level && entry.port != access_i.port) begin
      result = fsync_ctrl_pkg::PAIRED;  // partner from the other port.
    end else begin
      result = fsync_ctrl_pkg::MISMATCH;  // wrong level or repeat from same port.
    end
  end

  assign reply_o.result = result;
  assign reply_o.src    = entry.src;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else if (valid_i) begin
      // pairs and conflicts both free the id.
      pending_q[access_i.id] <= (result == fsync_ctrl_pkg::STORED);
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && result == fsync_ctrl_pkg::STORED) begin
      entry_q[access_i.id].level <= access_i.level;
      entry_q[access_i.id].src   <= access_i.src;
      entry_q[access_i.id].port  <= access_i.port;
    end
  end

endmodule

// File: fsync_port_ctrl.sv
`timescale 1ns/10ps

module fsync_port_ctrl #(
  parameter int unsigned PORT_ID = 0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      req_valid_i,
  input  fsync_pkg::sync_req_t      req_i,
  output logic                      req_ready_o,

  output logic                      rf_req_o,
  output fsync_ctrl_pkg::rf_access_t rf_access_o,
  input  logic                      rf_gnt_i,
  input  fsync_ctrl_pkg::rf_reply_t rf_reply_i,

  output logic                      local_push_o,
  output fsync_pkg::sync_rsp_t      local_rsp_o,
  input  logic                      local_full_i,

  output logic                      remote_push_o,
  output fsync_pkg::fwd_req_t       remote_req_o,
  input  logic                      remote_full_i,

  input  logic                      pop_err_i,
  output logic                      detected_error_o
);

  fsync_ctrl_pkg::ctrl_state_e   state_q, state_d;
  fsync_pkg::sync_req_t          req_q;    // accepted request.
  fsync_ctrl_pkg::rf_reply_t     reply_q;  // reply captured on grant.
  logic [fsync_pkg::LEVEL_W-1:0] level;
  logic                          paired;
  logic                          mismatch;
  logic                          err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= fsync_ctrl_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      fsync_ctrl_pkg::IDLE:  if (req_valid_i) state_d = fsync_ctrl_pkg::CHECK;  // accept.
      fsync_ctrl_pkg::CHECK: if (rf_gnt_i) state_d = fsync_ctrl_pkg::PUSH;      // lookup done.
      fsync_ctrl_pkg::PUSH:  state_d = fsync_ctrl_pkg::IDLE;                    // one cycle.
      default:               state_d = fsync_ctrl_pkg::IDLE;
    endcase
  end

  assign req_ready_o = (state_q == fsync_ctrl_pkg::IDLE);

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;  // hold the request for the whole transaction.
    end
    if (state_q == fsync_ctrl_pkg::CHECK && rf_gnt_i) begin
      reply_q <= rf_reply_i;  // reply only valid in the granted cycle.
    end
  end

  // highest set aggr bit gives the level, none set gives level 0.
  always_comb begin
    level = '0;
    for (int i = 0; i < fsync_pkg::AGGR_W; i++) begin
      if (req_q.aggr[i]) level = fsync_pkg::LEVEL_W'(i);
    end
  end

  assign rf_req_o          = (state_q == fsync_ctrl_pkg::CHECK);
  assign rf_access_o.level = level;
  assign rf_access_o.id    = req_q.id;
  assign rf_access_o.src   = req_q.src;
  assign rf_access_o.port  = PORT_ID[0];

  assign paired   = (reply_q.result == fsync_ctrl_pkg::PAIRED);
  assign mismatch = (reply_q.result == fsync_ctrl_pkg::MISMATCH);

  // root pairs and all errors answer locally, other pairs go one level up.
  assign local_push_o  = (state_q == fsync_ctrl_pkg::PUSH) & ((paired & req_q.root) | mismatch);
  assign remote_push_o = (state_q == fsync_ctrl_pkg::PUSH) & paired & ~req_q.root;

  assign local_rsp_o.wake  = 1'b1;
  assign local_rsp_o.error = mismatch;
  assign local_rsp_o.dst   = mismatch ? req_q.src : reply_q.src;  // error wakes the sender.

  assign remote_req_o.aggr = req_q.aggr >> 1;  // one level consumed.
  assign remote_req_o.id   = req_q.id;
  assign remote_req_o.src  = {req_q.src, fsync_pkg::SD_BOTH};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else if ((local_push_o && local_full_i) || (remote_push_o && remote_full_i) ||
                 pop_err_i) begin
      err_q <= 1'b1;  // sticky until reset.
    end
  end

  assign detected_error_o = err_q;

endmodule

// File: fsync_node.sv
`timescale 1ns/10ps

module fsync_node #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 req_valid_i      [2],
  input  fsync_pkg::sync_req_t req_i            [2],
  output logic                 req_ready_o      [2],

  output logic                 local_empty_o    [2],
  output fsync_pkg::sync_rsp_t local_rsp_o      [2],
  input  logic                 local_pop_i      [2],

  output logic                 remote_empty_o   [2],
  output fsync_pkg::fwd_req_t  remote_req_o     [2],
  input  logic                 remote_pop_i     [2],

  output logic                 detected_error_o [2]
);

  logic [1:0]                 rf_req;
  logic [1:0]                 rf_gnt;
  fsync_ctrl_pkg::rf_access_t rf_access [2];  // per-port lookup.
  fsync_ctrl_pkg::rf_access_t rf_access_win;  // granted lookup.
  logic                       rf_valid;
  fsync_ctrl_pkg::rf_reply_t  rf_reply;       // seen by both ports.

  logic                 local_push     [2];
  fsync_pkg::sync_rsp_t local_rsp      [2];
  logic                 local_full     [2];
  logic                 local_uflow    [2];
  logic                 remote_push    [2];
  fsync_pkg::fwd_req_t  remote_req     [2];
  logic                 remote_full    [2];
  logic                 remote_uflow   [2];
  logic                 pop_err        [2];

  for (genvar p = 0; p < 2; p++) begin : gen_port
    assign pop_err[p] = local_uflow[p] | remote_uflow[p];  // either FIFO popped empty.

    fsync_port_ctrl #(
      .PORT_ID ( p )
    ) i_port_ctrl (
      .clk_i            ( clk_i               ),
      .rst_ni           ( rst_ni              ),
      .req_valid_i      ( req_valid_i[p]      ),
      .req_i            ( req_i[p]            ),
      .req_ready_o      ( req_ready_o[p]      ),
      .rf_req_o         ( rf_req[p]           ),
      .rf_access_o      ( rf_access[p]        ),
      .rf_gnt_i         ( rf_gnt[p]           ),
      .rf_reply_i       ( rf_reply            ),
      .local_push_o     ( local_push[p]       ),
      .local_rsp_o      ( local_rsp[p]        ),
      .local_full_i     ( local_full[p]       ),
      .remote_push_o    ( remote_push[p]      ),
      .remote_req_o     ( remote_req[p]       ),
      .remote_full_i    ( remote_full[p]      ),
      .pop_err_i        ( pop_err[p]          ),
      .detected_error_o ( detected_error_o[p] )
    );

    fsync_fifo #(
      .FIFO_DEPTH ( FIFO_DEPTH            ),
      .element_t  ( fsync_pkg::sync_rsp_t )
    ) i_local_fifo (
      .clk_i       ( clk_i            ),
      .rst_ni      ( rst_ni           ),
      .push_i      ( local_push[p]    ),
      .element_i   ( local_rsp[p]     ),
      .pop_i       ( local_pop_i[p]   ),
      .element_o   ( local_rsp_o[p]   ),
      .empty_o     ( local_empty_o[p] ),
      .full_o      ( local_full[p]    ),
      .underflow_o ( local_uflow[p]   )
    );

    fsync_fifo #(
      .FIFO_DEPTH ( FIFO_DEPTH           ),
      .element_t  ( fsync_pkg::fwd_req_t )
    ) i_remote_fifo (
      .clk_i       ( clk_i             ),
      .rst_ni      ( rst_ni            ),
      .push_i      ( remote_push[p]    ),
      .element_i   ( remote_req[p]     ),
      .pop_i       ( remote_pop_i[p]   ),
      .element_o   ( remote_req_o[p]   ),
      .empty_o     ( remote_empty_o[p] ),
      .full_o      ( remote_full[p]    ),
      .underflow_o ( remote_uflow[p]   )
    );
  end

  fsync_rf_arbiter i_rf_arbiter (
    .clk_i    ( clk_i         ),
    .rst_ni   ( rst_ni        ),
    .req_i    ( rf_req        ),
    .access_i ( rf_access     ),
    .gnt_o    ( rf_gnt        ),
    .access_o ( rf_access_win ),
    .valid_o  ( rf_valid      )
  );

  fsync_local_rf i_local_rf (
    .clk_i    ( clk_i         ),
    .rst_ni   ( rst_ni        ),
    .valid_i  ( rf_valid      ),
    .access_i ( rf_access_win ),
    .reply_o  ( rf_reply      )
  );

endmodule

// File: tb_fsync_node.sv
`timescale 1ns/10ps

module tb_fsync_node;

  localparam int unsigned FIFO_DEPTH      = 2;
  localparam int unsigned CYCLES_PER_LINE = 20;  // timeout budget per data line.

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 req_valid    [2];
  fsync_pkg::sync_req_t req          [2];
  logic                 req_ready    [2];
  logic                 local_empty  [2];
  fsync_pkg::sync_rsp_t local_rsp    [2];
  logic                 local_pop    [2];
  logic                 remote_empty [2];
  fsync_pkg::fwd_req_t  remote_req   [2];
  logic                 remote_pop   [2];
  logic                 det_err      [2];

  logic [127:0] test_name;    // set by T lines.
  int unsigned  cycle_cnt = 0;
  int unsigned  cycle_limit;  // data file lines times the budget per line.

  fsync_node #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_dut (
    .clk_i            ( clk          ),
    .rst_ni           ( rst_n        ),
    .req_valid_i      ( req_valid    ),
    .req_i            ( req          ),
    .req_ready_o      ( req_ready    ),
    .local_empty_o    ( local_empty  ),
    .local_rsp_o      ( local_rsp    ),
    .local_pop_i      ( local_pop    ),
    .remote_empty_o   ( remote_empty ),
    .remote_req_o     ( remote_req   ),
    .remote_pop_i     ( remote_pop   ),
    .detected_error_o ( det_err      )
  );

  always #50 clk = ~clk;  // 100 ns period.

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, the DUT never delivered a result", cycle_cnt);
      stop_run("simulation timed out");
    end
  end

  task automatic stop_run(input string reason);
    $display("Errors found");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_val(input string what, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      $display("ERR %0s %0s expected %0h actual %0h", test_name, what, exp_val, act_val);
      stop_run("DUT output differs from the expected value");
    end
  endtask

  // waits for the next edge and releases one-cycle inputs 1 ns later.
  task automatic next_cycle();
    @(posedge clk);
    #1;
    for (int p = 0; p < 2; p++) begin
      req_valid[p]  = 1'b0;  // armed only while ready, so taken at this edge.
      local_pop[p]  = 1'b0;  // pops last one cycle.
      remote_pop[p] = 1'b0;
    end
  endtask

  task automatic send_req(input logic p, input logic root, input logic [3:0] aggr,
                          input logic [2:0] id, input logic [3:0] src);
    while (!req_ready[p] || req_valid[p]) next_cycle();  // port still busy.
    req[p].root  = root;
    req[p].aggr  = aggr;
    req[p].id    = id;
    req[p].src   = src;
    req_valid[p] = 1'b1;  // no time passes, so two ports can start together.
  endtask

  task automatic pop_local(input logic p, input logic [31:0] wake, input logic [31:0] error,
                           input logic [31:0] dst);
    while (local_empty[p]) next_cycle();
    check_val("local wake", wake, 32'(local_rsp[p].wake));
    check_val("local error", error, 32'(local_rsp[p].error));
    check_val("local dst", dst, 32'(local_rsp[p].dst));
    local_pop[p] = 1'b1;
    next_cycle();
  endtask

  task automatic pop_remote(input logic p, input logic [31:0] aggr, input logic [31:0] id,
                            input logic [31:0] src);
    while (remote_empty[p]) next_cycle();
    check_val("remote aggr", aggr, 32'(remote_req[p].aggr));
    check_val("remote id", id, 32'(remote_req[p].id));
    check_val("remote src", src, 32'(remote_req[p].src));
    remote_pop[p] = 1'b1;
    next_cycle();
  endtask

  initial begin
    int          fd;
    int          code;
    int          ch;
    int unsigned n_lines;
    logic [7:0]  cmd;
    logic [31:0] f0, f1, f2, f3, f4;
    bit          done;

    rst_n     = 1'b0;
    test_name = "reset";
    for (int p = 0; p < 2; p++) begin
      req_valid[p]  = 1'b0;
      req[p]        = '0;
      local_pop[p]  = 1'b0;
      remote_pop[p] = 1'b0;
    end

    fd = $fopen("fsync_testdata.txt", "r");
    if (fd == 0) stop_run("cannot open fsync_testdata.txt");
    n_lines = 0;
    ch = $fgetc(fd);
    while (ch != -1) begin
      if (ch == 10) n_lines++;
      ch = $fgetc(fd);
    end
    $fclose(fd);
    cycle_limit = n_lines * CYCLES_PER_LINE;

    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int p = 0; p < 2; p++) begin
      check_val("ready after reset", 1, 32'(req_ready[p]));
      check_val("local empty after reset", 1, 32'(local_empty[p]));
      check_val("remote empty after reset", 1, 32'(remote_empty[p]));
      check_val("error after reset", 0, 32'(det_err[p]));
    end

    fd = $fopen("fsync_testdata.txt", "r");
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) begin
        done = 1'b1;  // end of file.
      end else if (cmd == "#") begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) ch = $fgetc(fd);  // skip the comment line.
      end else if (cmd == "T") begin
        code = $fscanf(fd, "%s", test_name);
      end else if (cmd == "R") begin
        code = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
        if (code != 5) stop_run("malformed R line in the data file");
        send_req(f0[0], f1[0], f2[3:0], f3[2:0], f4[3:0]);
      end else if (cmd == "L" || cmd == "F") begin
        code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
        if (code != 4) stop_run("malformed L or F line in the data file");
        if (cmd == "L") pop_local(f0[0], f1, f2, f3);
        else pop_remote(f0[0], f1, f2, f3);
      end else if (cmd == "Q") begin
        code = $fscanf(fd, "%h %h %h", f0, f1, f2);
        check_val("local empty", f1, 32'(local_empty[f0[0]]));
        check_val("remote empty", f2, 32'(remote_empty[f0[0]]));
      end else if (cmd == "E") begin
        code = $fscanf(fd, "%h %h", f0, f1);
        check_val("detected error", f1, 32'(det_err[f0[0]]));
      end else if (cmd == "X") begin
        code = $fscanf(fd, "%h %h", f0, f1);
        if (f1 == 0) local_pop[f0[0]] = 1'b1;  // pop on an empty FIFO.
        else remote_pop[f0[0]] = 1'b1;
        next_cycle();
      end else if (cmd == "W") begin
        code = $fscanf(fd, "%h", f0);
        repeat (f0) next_cycle();
      end else begin
        stop_run("unknown command in the data file");
      end
    end
    $fclose(fd);

    $display("No errors");
    $finish;
  end

endmodule

// File: fsync_testdata.txt
# R port root aggr id src | L port wake error dst | F port aggr id src | Q port lempty rempty
# E port error | X port fifo(0 local 1 remote) | W cycles | T name, numbers in hex
T root_barrier
R 0 1 4 1 a
W 6
R 1 1 4 1 5
L 1 1 0 a
Q 0 1 1
T nonroot_forward
R 0 0 2 2 3
W 6
R 1 0 2 2 9
F 1 1 2 27
T level_mismatch
R 0 0 4 3 6
W 6
R 1 0 2 3 b
L 1 1 1 b
T same_port_repeat
R 0 0 1 4 2
R 0 0 1 4 7
L 0 1 1 7
T freed_ids
R 1 1 8 3 c
W 6
R 0 1 8 3 d
L 0 1 0 c
R 1 1 0 4 e
W 6
R 0 1 0 4 1
L 0 1 0 e
T simultaneous
R 0 0 2 5 4
R 1 0 4 6 8
W 6
R 1 0 2 5 1
R 0 0 4 6 2
F 1 1 5 07
F 0 2 6 0b
E 0 0
E 1 0
T overflow
R 1 0 1 7 3
R 1 0 1 7 3
R 1 0 1 7 4
R 1 0 1 7 5
R 1 0 1 7 6
R 1 0 1 7 8
W 4
E 1 1
E 0 0
L 1 1 1 3
L 1 1 1 5
Q 1 1 1
T underflow
X 0 1
W 2
E 0 1

// File: tb.f
fsync_pkg.sv
fsync_ctrl_pkg.sv
fsync_fifo.sv
fsync_rf_arbiter.sv
fsync_local_rf.sv
fsync_port_ctrl.sv
fsync_node.sv
tb_fsync_node.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_fsync_node
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
